/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= bumpy_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir

.PHONY: run build lint clean

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/bench_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module bench_clock (
	output logic clk,
	output logic resetN
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held low for the first 10 rising edges
	initial begin
		resetN = 1'b0;
		repeat (10) @(posedge clk);
		resetN <= 1'b1;
	end

endmodule

`default_nettype wire

/* bench/bumpy_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bumpy_tb;

	localparam int SEED = 11;
	localparam int SPEED_X = 120;
	localparam int SPEED_Y = 150;
	localparam geom_pkg::tile_coord_t START_TILE = '{col: 4'd0, row: 4'd4};

	// run length
	localparam int PHASES = 4;
	localparam int FRAMES = 400;
	localparam int FRAME_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = PHASES * FRAMES * FRAME_CYCLES + 100;

	// geometry in 1/64 pixel
	localparam int TILE_FX = geom_pkg::TILE_PX << geom_pkg::FIXED_SHIFT;
	localparam int CENTER_FX =
		((geom_pkg::TILE_PX - geom_pkg::BUMPY_PX) / 2) << geom_pkg::FIXED_SHIFT;
	localparam int JUMP_Y_FX = (geom_pkg::TILE_PX - 3 * 7) << geom_pkg::FIXED_SHIFT;
	localparam int REACH_FX = TILE_FX;
	localparam int BORDER_SHIFT_FX =
		(geom_pkg::TILE_PX / 2 + geom_pkg::BUMPY_PX / 2) << geom_pkg::FIXED_SHIFT;

	logic clk;
	logic resetN;
	logic start_of_frame;
	motion_pkg::keys_t keys;
	logic die;
	logic restart;
	geom_pkg::tile_map_t tile_map;
	geom_pkg::tile_coord_t teleport_target;
	geom_pkg::pixel_t offset_x;
	geom_pkg::pixel_t offset_y;
	motion_pkg::move_state_e state;

	// reference model state
	motion_pkg::move_state_e m_state;
	motion_pkg::collision_t m_coll;
	geom_pkg::fixed_t m_sx;
	geom_pkg::fixed_t m_sy;
	geom_pkg::fixed_t m_jx;
	geom_pkg::fixed_t m_jy;
	geom_pkg::fixed_t m_px;
	geom_pkg::fixed_t m_py;
	logic m_floor;

	// stimulus bookkeeping
	int cycle_count = 0;
	int phase;
	int frame;
	int cyc;
	int hold_frames;
	logic [3:0] key_bits;
	geom_pkg::tile_map_t next_map;
	geom_pkg::tile_coord_t next_target;

	bench_clock clock_gen (
		.clk    (clk),
		.resetN (resetN)
	);

	bumpy_core #(
		.SPEED_X    (SPEED_X),
		.SPEED_Y    (SPEED_Y),
		.START_TILE (START_TILE)
	) dut_i (
		.clk             (clk),
		.resetN          (resetN),
		.start_of_frame  (start_of_frame),
		.keys            (keys),
		.die             (die),
		.restart         (restart),
		.tile_map        (tile_map),
		.teleport_target (teleport_target),
		.offset_x        (offset_x),
		.offset_y        (offset_y),
		.state           (state)
	);

	task automatic check_state(input string name, input motion_pkg::move_state_e got,
			input motion_pkg::move_state_e exp);
		if (got !== exp) begin
			$display("FAILED time %0t: %s got %s expected %s",
				$time, name, got.name(), exp.name());
			$display("STATUS: FAIL");
			$fatal(1, "movement state mismatch");
		end
	endtask

	task automatic check_offset(input string name, input geom_pkg::pixel_t got,
			input geom_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("FAILED time %0t: %s got %0d expected %0d", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "sprite offset mismatch");
		end
	endtask

	// tile under a pixel, off the grid counts as border
	function automatic geom_pkg::tile_kind_t tile_under(input int x, input int y,
			input geom_pkg::tile_map_t tiles);
		int col;
		int row;
		col = x >>> 6;
		row = y >>> 6;
		if (col < 0 || row < 0 ||
				col > geom_pkg::GRID_COLS - 1 || row > geom_pkg::GRID_ROWS - 1)
			return geom_pkg::TILE_BORDER;
		return tiles[row * geom_pkg::GRID_COLS + col];
	endfunction

	// foot tile wins, then the left side, then the right side
	function automatic motion_pkg::collision_t collide(input geom_pkg::fixed_t x_fx,
			input geom_pkg::fixed_t y_fx, input geom_pkg::tile_map_t tiles);
		int px;
		int py;
		geom_pkg::tile_kind_t foot;
		motion_pkg::collision_t c;
		px = x_fx >>> geom_pkg::FIXED_SHIFT;
		py = y_fx >>> geom_pkg::FIXED_SHIFT;
		c = '0;
		foot = tile_under(px + geom_pkg::BUMPY_PX / 2, py + geom_pkg::BUMPY_PX, tiles);
		if (foot == geom_pkg::TILE_STEP) begin
			c.step = 1'b1;
			c.hit_edge = geom_pkg::EDGE_BOTTOM;
		end
		else if (foot == geom_pkg::TILE_TELEPORT) begin
			c.teleport = 1'b1;
			c.hit_edge = geom_pkg::EDGE_BOTTOM;
		end
		else if (foot == geom_pkg::TILE_FREE) begin
			c.free = 1'b1;
			c.hit_edge = geom_pkg::EDGE_BOTTOM;
		end
		else if (tile_under(px - 1, py + geom_pkg::BUMPY_PX / 2, tiles) ==
				geom_pkg::TILE_BORDER) begin
			c.border = 1'b1;
			c.hit_edge = geom_pkg::EDGE_LEFT;
		end
		else if (tile_under(px + geom_pkg::BUMPY_PX, py + geom_pkg::BUMPY_PX / 2, tiles) ==
				geom_pkg::TILE_BORDER) begin
			c.border = 1'b1;
			c.hit_edge = geom_pkg::EDGE_RIGHT;
		end
		return c;
	endfunction

	// controller rule for one frame
	function automatic motion_pkg::move_state_e next_state_of(
			input motion_pkg::move_state_e cur,
			input motion_pkg::keys_t k, input logic d, input logic rs,
			input motion_pkg::collision_t c);
		if (d)
			return motion_pkg::S_DIE;
		if (cur == motion_pkg::S_RESET)
			return motion_pkg::S_IDLE;
		if (cur == motion_pkg::S_DIE) begin
			if (rs)
				return motion_pkg::S_RESET;
			return motion_pkg::S_DIE;
		end
		if (k.up) begin
			// climbing only over a free tile
			if (c.free && c.hit_edge == geom_pkg::EDGE_BOTTOM)
				return motion_pkg::S_UP;
			return motion_pkg::S_IDLE;
		end
		if (k.down)
			return motion_pkg::S_DOWN;
		if (k.left)
			return motion_pkg::S_LEFT;
		if (k.right)
			return motion_pkg::S_RIGHT;
		return motion_pkg::S_IDLE;
	endfunction

	// sprite centred in a tile
	function automatic geom_pkg::fixed_t place_in_tile(input geom_pkg::tile_idx_t idx);
		geom_pkg::fixed_t f;
		f = idx;
		return f * TILE_FX + CENTER_FX;
	endfunction

	// random map, shaped per phase
	task automatic build_map(input int ph, output geom_pkg::tile_map_t map);
		int row;
		int col;
		int pick;
		geom_pkg::tile_kind_t kind;
		map = '0;
		for (row = 0; row < geom_pkg::GRID_ROWS; row++) begin
			for (col = 0; col < geom_pkg::GRID_COLS; col++) begin
				pick = $urandom % 8;
				kind = (pick < 5) ? geom_pkg::TILE_FREE : geom_pkg::TILE_STEP;
				case (ph)
					// step floor on the start row
					0: if (row == 4) kind = geom_pkg::TILE_STEP;
					1: if (row >= 4) kind = geom_pkg::TILE_STEP;
					// walls at both sides
					2: begin
						if (col == 0 || col == geom_pkg::GRID_COLS - 1)
							kind = geom_pkg::TILE_BORDER;
						else if (row == 4)
							kind = geom_pkg::TILE_STEP;
					end
					default: begin
						if (pick == 7 || (row == 4 && pick[0]))
							kind = geom_pkg::TILE_TELEPORT;
					end
				endcase
				map[row * geom_pkg::GRID_COLS + col] = kind;
			end
		end
	endtask

	assign m_floor = (m_coll.hit_edge == geom_pkg::EDGE_BOTTOM);

	// cycle model, reads the values before this edge
	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			m_state <= motion_pkg::S_RESET;
			m_coll <= '0;
			m_sx <= '0;
			m_sy <= '0;
			m_jx <= '0;
			m_jy <= '0;
			m_px <= place_in_tile(START_TILE.col);
			m_py <= place_in_tile(START_TILE.row);
		end
		else begin
			m_coll <= collide(m_px, m_py, tile_map);
			if (start_of_frame)
				m_state <= next_state_of(m_state, keys, die, restart, m_coll);
			// jump origin follows the feet on a step or while climbing
			if (m_floor && (m_coll.step || (m_state == motion_pkg::S_UP && m_coll.free))) begin
				m_jx <= m_px;
				m_jy <= m_py;
			end
			else if (m_coll.border && m_coll.hit_edge == geom_pkg::EDGE_LEFT)
				m_jx <= m_px - BORDER_SHIFT_FX;
			else if (m_coll.border && m_coll.hit_edge == geom_pkg::EDGE_RIGHT)
				m_jx <= m_px + BORDER_SHIFT_FX;
			// vertical speed
			case (m_state)
				motion_pkg::S_RESET: m_sy <= '0;
				motion_pkg::S_IDLE, motion_pkg::S_LEFT, motion_pkg::S_RIGHT: begin
					if (m_floor && m_coll.step && m_sy >= 0)
						m_sy <= -SPEED_Y;
					else if (m_sy <= 0 && m_py < m_jy - JUMP_Y_FX)
						m_sy <= SPEED_Y;
				end
				motion_pkg::S_DOWN: m_sy <= SPEED_Y;
				motion_pkg::S_UP: m_sy <= -SPEED_Y;
				// a dead sprite stays put
				default: m_sy <= '0;
			endcase
			// horizontal speed, halts before leaving the reach
			if (m_state == motion_pkg::S_LEFT)
				m_sx <= (m_sx <= 0 && m_px + m_sx < m_jx - REACH_FX) ? 0 : -SPEED_X;
			else if (m_state == motion_pkg::S_RIGHT)
				m_sx <= (m_sx >= 0 && m_px + m_sx > m_jx + REACH_FX) ? 0 : SPEED_X;
			else
				m_sx <= '0;
			// teleport any cycle, otherwise step once per frame
			if (m_floor && m_coll.teleport) begin
				m_px <= place_in_tile(teleport_target.col);
				m_py <= place_in_tile(teleport_target.row);
			end
			else if (start_of_frame) begin
				m_px <= m_px + m_sx;
				m_py <= m_py + m_sy;
			end
		end
	end

	// compare on the falling edge where everything is settled
	always @(negedge clk) begin
		if (resetN) begin
			check_state("state", state, m_state);
			check_offset("offset_x", offset_x,
				geom_pkg::pixel_t'(m_px >>> geom_pkg::FIXED_SHIFT));
			check_offset("offset_y", offset_y,
				geom_pkg::pixel_t'(m_py >>> geom_pkg::FIXED_SHIFT));
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, stimulus did not finish", cycle_count);
			$display("STATUS: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	initial begin
		void'($urandom(SEED));
		start_of_frame = 1'b0;
		keys = '0;
		die = 1'b0;
		restart = 1'b0;
		teleport_target = START_TILE;
		build_map(0, next_map);
		tile_map = next_map;
		hold_frames = 0;

		// start position straight out of reset
		@(posedge resetN);
		@(negedge clk);
		check_state("state", state, motion_pkg::S_RESET);
		check_offset("offset_x", offset_x, 11'sd24);
		check_offset("offset_y", offset_y, 11'sd280);

		for (phase = 0; phase < PHASES; phase++) begin
			for (frame = 0; frame < FRAMES; frame++) begin
				for (cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
					@(posedge clk);
					if (cyc == 0) begin
						start_of_frame <= 1'b1;
						// new map and target at each phase start
						if (frame == 0 && phase > 0) begin
							build_map(phase, next_map);
							tile_map <= next_map;
							next_target.col = 4'($urandom % geom_pkg::GRID_COLS);
							next_target.row = 4'($urandom % geom_pkg::GRID_ROWS);
							teleport_target <= next_target;
						end
						// keys held 1 to 6 frames, mostly a single direction
						if (hold_frames == 0) begin
							case ($urandom % 6)
								0, 1, 2, 3: key_bits = 4'b0001 << ($urandom % 4);
								4: key_bits = 4'b0000;
								default: key_bits = 4'($urandom % 16);
							endcase
							keys <= key_bits;
							hold_frames = 1 + $urandom % 6;
						end
						hold_frames--;
						die <= (phase + frame > 0) && ($urandom % 48 == 0 || frame == 200);
						restart <= ($urandom % 4 == 0);
					end
					else begin
						start_of_frame <= 1'b0;
					end
					// first frame leaves reset
					if (phase == 0 && frame == 0 && cyc == 1) begin
						@(negedge clk);
						check_state("state", state, motion_pkg::S_IDLE);
					end
				end
			end
		end

		@(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/geom_pkg.sv
verilog/motion_pkg.sv
verilog/bumpy_controller.sv
verilog/tile_collision.sv
verilog/bumpy_move.sv
verilog/bumpy_core.sv
bench/bench_clock.sv
bench/bumpy_tb.sv

/* verilog/bumpy_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module bumpy_controller (
	input wire logic clk,
	input wire logic resetN,
	input wire logic start_of_frame,
	input wire motion_pkg::keys_t keys,
	input wire logic die,
	input wire logic restart,
	input wire motion_pkg::collision_t coll,
	output motion_pkg::move_state_e state
);

	motion_pkg::move_state_e next_state;
	logic can_climb;

	// climbing needs a free tile right under the feet
	assign can_climb = coll.free && (coll.hit_edge == geom_pkg::EDGE_BOTTOM);

	// next state chosen from keys and level inputs
	always_comb begin
		next_state = state;
		if (die) begin
			// die wins from any state
			next_state = motion_pkg::S_DIE;
		end
		else begin
			case (state)
				motion_pkg::S_RESET: begin
					next_state = motion_pkg::S_IDLE;
				end
				motion_pkg::S_DIE: begin
					// stay dead until restart
					if (restart)
						next_state = motion_pkg::S_RESET;
				end
				default: begin
					// key priority up, down, left, right
					if (keys.up) begin
						if (can_climb)
							next_state = motion_pkg::S_UP;
						else
							next_state = motion_pkg::S_IDLE;
					end
					else if (keys.down) begin
						next_state = motion_pkg::S_DOWN;
					end
					else if (keys.left) begin
						next_state = motion_pkg::S_LEFT;
					end
					else if (keys.right) begin
						next_state = motion_pkg::S_RIGHT;
					end
					else begin
						next_state = motion_pkg::S_IDLE;
					end
				end
			endcase
		end
	end

	// state register, updates once per frame only
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= motion_pkg::S_RESET;
		end
		else if (start_of_frame) begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

/* verilog/bumpy_core.sv */
`timescale 1ns/100ps
`default_nettype none

module bumpy_core #(
	parameter int SPEED_X = 120,
	parameter int SPEED_Y = 150,
	parameter geom_pkg::tile_coord_t START_TILE = '{col: 4'd0, row: 4'd4}
) (
	input wire logic clk,
	input wire logic resetN,
	input wire logic start_of_frame,
	input wire motion_pkg::keys_t keys,
	input wire logic die,
	input wire logic restart,
	input wire geom_pkg::tile_map_t tile_map,
	input wire geom_pkg::tile_coord_t teleport_target,
	output geom_pkg::pixel_t offset_x,
	output geom_pkg::pixel_t offset_y,
	output motion_pkg::move_state_e state
);

	// loop between the three blocks
	geom_pkg::fixed_t pos_x;
	geom_pkg::fixed_t pos_y;
	motion_pkg::collision_t coll;

	// movement state from keys
	bumpy_controller u_controller (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.keys           (keys),
		.die            (die),
		.restart        (restart),
		.coll           (coll),
		.state          (state)
	);

	// tile lookup around the sprite
	tile_collision u_collision (
		.clk      (clk),
		.resetN   (resetN),
		.pos_x    (pos_x),
		.pos_y    (pos_y),
		.tile_map (tile_map),
		.coll     (coll)
	);

	// speeds and position
	bumpy_move #(
		.SPEED_X    (SPEED_X),
		.SPEED_Y    (SPEED_Y),
		.START_TILE (START_TILE)
	) u_move (
		.clk             (clk),
		.resetN          (resetN),
		.start_of_frame  (start_of_frame),
		.state           (state),
		.coll            (coll),
		.teleport_target (teleport_target),
		.pos_x           (pos_x),
		.pos_y           (pos_y),
		.offset_x        (offset_x),
		.offset_y        (offset_y)
	);

endmodule

`default_nettype wire

/* verilog/bumpy_move.sv */
`timescale 1ns/100ps
`default_nettype none

module bumpy_move #(
	parameter int SPEED_X = 120,
	parameter int SPEED_Y = 150,
	parameter geom_pkg::tile_coord_t START_TILE = '{col: 4'd0, row: 4'd4}
) (
	input wire logic clk,
	input wire logic resetN,
	input wire logic start_of_frame,
	input wire motion_pkg::move_state_e state,
	input wire motion_pkg::collision_t coll,
	input wire geom_pkg::tile_coord_t teleport_target,
	output geom_pkg::fixed_t pos_x,
	output geom_pkg::fixed_t pos_y,
	output geom_pkg::pixel_t offset_x,
	output geom_pkg::pixel_t offset_y
);

	// sizes in fixed point
	localparam geom_pkg::fixed_t TILE_FX = geom_pkg::TILE_PX << geom_pkg::FIXED_SHIFT;
	localparam geom_pkg::fixed_t BUMPY_FX = geom_pkg::BUMPY_PX << geom_pkg::FIXED_SHIFT;
	localparam geom_pkg::fixed_t STEP_FX = 7 << geom_pkg::FIXED_SHIFT;
	// sprite centred inside a tile
	localparam geom_pkg::fixed_t CENTER_FX = TILE_FX / 2 - BUMPY_FX / 2;
	// jump reach, up is a tile less three steps
	localparam geom_pkg::fixed_t JUMP_LIMIT_Y = TILE_FX - 3 * STEP_FX;
	localparam geom_pkg::fixed_t JUMP_LIMIT_X = TILE_FX;

	geom_pkg::fixed_t speed_x;
	geom_pkg::fixed_t speed_y;
	geom_pkg::fixed_t jump_start_x;
	geom_pkg::fixed_t jump_start_y;
	logic on_bottom;

	// top-left of a centred sprite in the given tile
	function automatic geom_pkg::fixed_t tile_origin(input geom_pkg::tile_idx_t idx);
		return geom_pkg::fixed_t'(idx) * TILE_FX + CENTER_FX;
	endfunction

	assign on_bottom = (coll.hit_edge == geom_pkg::EDGE_BOTTOM);

	// jump origin
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			jump_start_x <= '0;
			jump_start_y <= '0;
		end
		else if ((coll.step && on_bottom) ||
				(state == motion_pkg::S_UP && coll.free && on_bottom)) begin
			jump_start_x <= pos_x;
			jump_start_y <= pos_y;
		end
		else if (coll.border) begin
			// push the reach window away from the wall
			if (coll.hit_edge == geom_pkg::EDGE_LEFT)
				jump_start_x <= pos_x - JUMP_LIMIT_X / 2 - BUMPY_FX / 2;
			else if (coll.hit_edge == geom_pkg::EDGE_RIGHT)
				jump_start_x <= pos_x + JUMP_LIMIT_X / 2 + BUMPY_FX / 2;
		end
	end

	// vertical speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_y <= '0;
		end
		else begin
			case (state)
				motion_pkg::S_RESET: speed_y <= '0;
				motion_pkg::S_IDLE, motion_pkg::S_LEFT, motion_pkg::S_RIGHT: begin
					// bounce off a step, fall back past the jump limit
					if (coll.step && on_bottom && speed_y >= 0)
						speed_y <= -SPEED_Y;
					else if (pos_y < jump_start_y - JUMP_LIMIT_Y && speed_y <= 0)
						speed_y <= SPEED_Y;
				end
				motion_pkg::S_DOWN: speed_y <= SPEED_Y;
				motion_pkg::S_UP: speed_y <= -SPEED_Y;
				// no motion while dead
				default: speed_y <= '0;
			endcase
		end
	end

	// horizontal speed, stops one tile from the origin
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_x <= '0;
		end
		else begin
			case (state)
				motion_pkg::S_LEFT: begin
					if (pos_x < jump_start_x - JUMP_LIMIT_X - speed_x && speed_x <= 0)
						speed_x <= '0;
					else
						speed_x <= -SPEED_X;
				end
				motion_pkg::S_RIGHT: begin
					if (pos_x > jump_start_x + JUMP_LIMIT_X - speed_x && speed_x >= 0)
						speed_x <= '0;
					else
						speed_x <= SPEED_X;
				end
				default: speed_x <= '0;
			endcase
		end
	end

	// position, teleport beats the per-frame step
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos_x <= tile_origin(START_TILE.col);
			pos_y <= tile_origin(START_TILE.row);
		end
		else if (coll.teleport && on_bottom) begin
			pos_x <= tile_origin(teleport_target.col);
			pos_y <= tile_origin(teleport_target.row);
		end
		else if (start_of_frame) begin
			pos_x <= pos_x + speed_x;
			pos_y <= pos_y + speed_y;
		end
	end

	// back to whole pixels
	assign offset_x = geom_pkg::pixel_t'(pos_x >>> geom_pkg::FIXED_SHIFT);
	assign offset_y = geom_pkg::pixel_t'(pos_y >>> geom_pkg::FIXED_SHIFT);

endmodule

`default_nettype wire

/* verilog/geom_pkg.sv */
`default_nettype none

package geom_pkg;

	// fixed point scale, 1/64 pixel per lsb
	localparam int FIXED_SHIFT = 6;

	// screen and tile dimensions in pixels
	localparam int TILE_PX = 64;
	localparam int BUMPY_PX = 16;

	// playfield grid
	localparam int GRID_COLS = 10;
	localparam int GRID_ROWS = 8;

	// position or speed in 1/64 pixel
	typedef logic signed [31:0] fixed_t;

	// top-left corner on screen
	typedef logic signed [10:0] pixel_t;

	// one grid column or row
	typedef logic [3:0] tile_idx_t;

	// col in the high nibble like the teleport byte
	typedef struct packed {
		tile_idx_t col;
		tile_idx_t row;
	} tile_coord_t;

	// tile kind codes
	typedef logic [1:0] tile_kind_t;
	localparam tile_kind_t TILE_FREE = 2'd0;
	localparam tile_kind_t TILE_STEP = 2'd1;
	localparam tile_kind_t TILE_TELEPORT = 2'd2;
	localparam tile_kind_t TILE_BORDER = 2'd3;

	// whole map, entry row*GRID_COLS+col
	typedef tile_kind_t [GRID_COLS*GRID_ROWS-1:0] tile_map_t;

	// one-hot hit edge, zero when nothing hit
	typedef logic [3:0] edge_code_t;
	localparam edge_code_t EDGE_NONE = 4'b0000;
	localparam edge_code_t EDGE_BOTTOM = 4'b0001;
	localparam edge_code_t EDGE_RIGHT = 4'b0010;
	localparam edge_code_t EDGE_TOP = 4'b0100;
	localparam edge_code_t EDGE_LEFT = 4'b1000;

endpackage

`default_nettype wire

/* verilog/motion_pkg.sv */
`default_nettype none

package motion_pkg;

	// movement state of the sprite
	typedef enum logic [2:0] {
		S_RESET,
		S_IDLE,
		S_LEFT,
		S_RIGHT,
		S_DOWN,
		S_UP,
		S_DIE
	} move_state_e;

	// direction key levels
	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} keys_t;

	// collision flags plus the edge that was hit
	typedef struct packed {
		logic step;
		logic free;
		logic border;
		logic teleport;
		geom_pkg::edge_code_t hit_edge;
	} collision_t;

endpackage

`default_nettype wire

/* verilog/tile_collision.sv */
`timescale 1ns/100ps
`default_nettype none

module tile_collision (
	input wire logic clk,
	input wire logic resetN,
	input wire geom_pkg::fixed_t pos_x,
	input wire geom_pkg::fixed_t pos_y,
	input wire geom_pkg::tile_map_t tile_map,
	output motion_pkg::collision_t coll
);

	// pixel to tile index shift
	localparam int TILE_SHIFT = $clog2(geom_pkg::TILE_PX);
	localparam int HALF_PX = geom_pkg::BUMPY_PX / 2;

	geom_pkg::fixed_t px;
	geom_pkg::fixed_t py;
	geom_pkg::tile_kind_t foot_kind;
	geom_pkg::tile_kind_t left_kind;
	geom_pkg::tile_kind_t right_kind;
	motion_pkg::collision_t next_coll;

	// kind of the tile under one pixel, outside the grid reads as border
	function automatic geom_pkg::tile_kind_t kind_at(input geom_pkg::fixed_t x,
			input geom_pkg::fixed_t y, input geom_pkg::tile_map_t tiles);
		geom_pkg::fixed_t col;
		geom_pkg::fixed_t row;
		col = x >>> TILE_SHIFT;
		row = y >>> TILE_SHIFT;
		if (col < 0 || row < 0 || col >= geom_pkg::GRID_COLS || row >= geom_pkg::GRID_ROWS)
			return geom_pkg::TILE_BORDER;
		return tiles[row * geom_pkg::GRID_COLS + col];
	endfunction

	// sprite top-left in whole pixels
	assign px = pos_x >>> geom_pkg::FIXED_SHIFT;
	assign py = pos_y >>> geom_pkg::FIXED_SHIFT;

	// centre column one row below the sprite
	assign foot_kind = kind_at(px + HALF_PX, py + geom_pkg::BUMPY_PX, tile_map);
	// centre row just outside each side
	assign left_kind = kind_at(px - 1, py + HALF_PX, tile_map);
	assign right_kind = kind_at(px + geom_pkg::BUMPY_PX, py + HALF_PX, tile_map);

	// foot first, then left side, then right side
	always_comb begin
		next_coll = '0;
		next_coll.hit_edge = geom_pkg::EDGE_NONE;
		case (foot_kind)
			geom_pkg::TILE_STEP: begin
				next_coll.step = 1'b1;
				next_coll.hit_edge = geom_pkg::EDGE_BOTTOM;
			end
			geom_pkg::TILE_TELEPORT: begin
				next_coll.teleport = 1'b1;
				next_coll.hit_edge = geom_pkg::EDGE_BOTTOM;
			end
			geom_pkg::TILE_FREE: begin
				next_coll.free = 1'b1;
				next_coll.hit_edge = geom_pkg::EDGE_BOTTOM;
			end
			default: begin
				if (left_kind == geom_pkg::TILE_BORDER) begin
					next_coll.border = 1'b1;
					next_coll.hit_edge = geom_pkg::EDGE_LEFT;
				end
				else if (right_kind == geom_pkg::TILE_BORDER) begin
					next_coll.border = 1'b1;
					next_coll.hit_edge = geom_pkg::EDGE_RIGHT;
				end
			end
		endcase
	end

	// one cycle from position to flags
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			coll <= '0;
		else
			coll <= next_coll;
	end

endmodule

`default_nettype wire
